// File: project.f
+incdir+rtl
rtl/cfg_pkg.sv
rtl/iic_req_if.sv
rtl/cfg_fsm.sv
rtl/step_counter.sv
rtl/cmd_source.sv
rtl/status_capture.sv
rtl/iic_issuer.sv
rtl/ms7200_cfg_top.sv
testbench/cfg_chk.sv
testbench/tb_top.sv

// File: rtl/cfg_fsm.sv
`default_nettype none

module cfg_fsm (
    input  wire               clk,
    input  wire               rstn,
    iic_req_if.ctrl           req,
    output cfg_pkg::phase_t   phase,
    input  wire [4:0]         step,
    input  wire               last,
    input  wire               lock_event,
    input  wire [7:0]         data_out,
    input  wire               byte_over,
    output logic              init_over
);

    logic [7:0] rd_byte;
    logic [1:0] arm;

    // Readback of the connection check register.
    always_ff @(posedge clk)
    begin
        if (byte_over && phase == cfg_pkg::CONNECT && step == 5'd1)
            rd_byte <= data_out;
    end

    // The two arm stages give step_counter and cmd_source time to settle
    // the next address before valid rises.
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            phase     <= cfg_pkg::IDLE;
            arm       <= 2'b00;
            req.valid <= 1'b0;
            req.write <= 1'b1;
            init_over <= 1'b0;
        end
        else
        begin
            arm <= {arm[0], req.done || phase == cfg_pkg::IDLE};

            if (arm[1])
            begin
                req.valid <= 1'b1;
                req.write <= !(phase == cfg_pkg::POLL ||
                               (phase == cfg_pkg::CONNECT && step == 5'd1));
            end
            else if (req.valid && req.ready)
                req.valid <= 1'b0;

            case (phase)
                cfg_pkg::IDLE:
                    phase <= cfg_pkg::CONNECT;
                cfg_pkg::CONNECT:
                    if (req.done && last && rd_byte == cfg_pkg::CONNECT_MAGIC)
                        phase <= cfg_pkg::INIT;
                cfg_pkg::INIT:
                    if (req.done && last)
                        phase <= cfg_pkg::POLL;
                cfg_pkg::POLL:
                    if (lock_event)
                        phase <= cfg_pkg::SETTINGS;
                cfg_pkg::SETTINGS:
                    if (req.done && last)
                    begin
                        phase     <= cfg_pkg::POLL;
                        init_over <= 1'b1;
                    end
                default:
                    phase <= cfg_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/cfg_pkg.sv
`default_nettype none

package cfg_pkg;

    typedef enum logic [2:0] {
        IDLE,
        CONNECT,
        INIT,
        POLL,
        SETTINGS
    } phase_t;

    // Frequency status from 0x209C..0x209F. Byte 0 is the lowest address.
    typedef union packed {
        logic [3:0][7:0] bytes;
        struct packed {
            logic [13:0] upper;
            logic [1:0]  lock;
            logic [15:0] lower;
        } fields;
    } status_word_t;

    typedef logic [15:0] reg_addr_t;
    typedef logic [7:0]  reg_data_t;

    localparam reg_addr_t CONNECT_ADDR  = 16'h0003;
    localparam reg_data_t CONNECT_MAGIC = 8'h5A;
    localparam reg_addr_t STATUS_BASE   = 16'h209C;

    localparam int CONNECT_LEN  = 2;
    localparam int INIT_LEN     = 16;
    localparam int STATUS_LEN   = 4;
    localparam int SETTINGS_LEN = 7;

    localparam logic [1:0] LOCK_IDLE  = 2'b00;
    localparam logic [1:0] LOCK_FOUND = 2'b10;

endpackage

`default_nettype wire

// File: rtl/cmd_source.sv
`default_nettype none

module cmd_source (
    input  wire              clk,
    input  wire              rstn,
    input  cfg_pkg::phase_t  phase,
    input  wire [4:0]        step,
    iic_req_if.source        req
);

    `include "init_table.svh"

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            req.addr  <= 16'h0000;
            req.wdata <= 8'h00;
        end
        else
        begin
            case (phase)
                cfg_pkg::CONNECT:
                begin
                    req.addr  <= cfg_pkg::CONNECT_ADDR;
                    req.wdata <= cfg_pkg::CONNECT_MAGIC;
                end
                cfg_pkg::INIT:
                    {req.addr, req.wdata} <= INIT_TABLE[step[3:0]];
                cfg_pkg::SETTINGS:
                    {req.addr, req.wdata} <= SETTINGS_TABLE[step[2:0]];
                cfg_pkg::POLL:
                begin
                    req.addr  <= cfg_pkg::STATUS_BASE + 16'(step);
                    req.wdata <= 8'h00;
                end
                default:
                begin
                    req.addr  <= 16'h0000;
                    req.wdata <= 8'h00;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/iic_issuer.sv
`default_nettype none

module iic_issuer (
    input  wire          clk,
    input  wire          rstn,
    iic_req_if.issuer    req,
    input  wire          busy,
    output logic         iic_trig,
    output logic         w_r,
    output logic [15:0]  addr,
    output logic [7:0]   data_in
);

    logic pend;
    logic busy_1d;
    logic busy_fall;
    logic take;

    assign busy_fall = busy_1d & ~busy;
    assign req.ready = ~pend;
    assign take      = req.valid & req.ready;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            busy_1d  <= 1'b0;
            pend     <= 1'b0;
            req.done <= 1'b0;
            iic_trig <= 1'b0;
            w_r      <= 1'b1;
            addr     <= 16'h0000;
            data_in  <= 8'h00;
        end
        else
        begin
            busy_1d  <= busy;
            iic_trig <= take;
            // The master raises busy some cycles after trig, so pend bridges that gap.
            req.done <= pend & busy_fall;
            if (take)
            begin
                pend    <= 1'b1;
                w_r     <= req.write;
                addr    <= req.addr;
                data_in <= req.wdata;
            end
            else if (busy_fall)
                pend <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/iic_req_if.sv
`default_nettype none

// One register transaction handed from the FSM to the I2C issuer.
interface iic_req_if;
    logic               valid;
    logic               ready;
    logic               done;
    logic               write;
    cfg_pkg::reg_addr_t addr;
    cfg_pkg::reg_data_t wdata;

    modport ctrl (output valid, output write, input ready, input done);
    modport source (output addr, output wdata);
    modport issuer (input valid, input write, input addr, input wdata,
                    output ready, output done);
endinterface

`default_nettype wire

// File: rtl/init_table.svh
`ifndef INIT_TABLE_SVH
`define INIT_TABLE_SVH

// Entries are {register address, value}.
localparam logic [23:0] INIT_TABLE [cfg_pkg::INIT_LEN] = '{
    {16'h0204, 8'h02}, {16'h0205, 8'h40}, {16'h0004, 8'h01}, {16'h0009, 8'h26},
    {16'h102E, 8'h01}, {16'h1025, 8'hB0}, {16'h102D, 8'h83}, {16'h1000, 8'h20},
    {16'h100F, 8'h04}, {16'h0003, 8'hC3}, {16'h103B, 8'h02}, {16'h00E1, 8'h00},
    {16'h00A8, 8'h08}, {16'h000A, 8'h00}, {16'h0016, 8'h02}, {16'h00E2, 8'h01}
};

// Written once per detected lock.
localparam logic [23:0] SETTINGS_TABLE [cfg_pkg::SETTINGS_LEN] = '{
    {16'h1010, 8'h01},
    {16'h1024, 8'h00},
    {16'h0200, 8'h00},
    {16'h1024, 8'h70},
    {16'h0200, 8'h07},
    {16'h0215, 8'h01},
    {16'h0215, 8'h00}
};

`endif

// File: rtl/ms7200_cfg_top.sv
`default_nettype none

module ms7200_cfg_top (
    input  wire         clk,
    input  wire         rstn,
    output wire         init_over,
    output wire         iic_trig,
    output wire         w_r,
    output wire [15:0]  addr,
    output wire [7:0]   data_in,
    input  wire         busy,
    input  wire [7:0]   data_out,
    input  wire         byte_over
);

    iic_req_if req ();

    cfg_pkg::phase_t phase;
    wire [4:0]       step;
    wire             last;
    wire             lock_event;

    cfg_fsm u_fsm (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req.ctrl),
        .phase      (phase),
        .step       (step),
        .last       (last),
        .lock_event (lock_event),
        .data_out   (data_out),
        .byte_over  (byte_over),
        .init_over  (init_over)
    );

    step_counter u_step (
        .clk   (clk),
        .rstn  (rstn),
        .phase (phase),
        .done  (req.done),
        .step  (step),
        .last  (last)
    );

    cmd_source u_cmd (
        .clk   (clk),
        .rstn  (rstn),
        .phase (phase),
        .step  (step),
        .req   (req.source)
    );

    status_capture u_status (
        .clk        (clk),
        .rstn       (rstn),
        .phase      (phase),
        .step       (step),
        .done       (req.done),
        .byte_over  (byte_over),
        .data_out   (data_out),
        .lock_event (lock_event)
    );

    iic_issuer u_issuer (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req.issuer),
        .busy     (busy),
        .iic_trig (iic_trig),
        .w_r      (w_r),
        .addr     (addr),
        .data_in  (data_in)
    );

endmodule

`default_nettype wire

// File: rtl/status_capture.sv
`default_nettype none

module status_capture (
    input  wire              clk,
    input  wire              rstn,
    input  cfg_pkg::phase_t  phase,
    input  wire [4:0]        step,
    input  wire              done,
    input  wire              byte_over,
    input  wire [7:0]        data_out,
    output logic             lock_event
);

    cfg_pkg::status_word_t cur;
    cfg_pkg::status_word_t prev;
    logic                  word_end;

    assign word_end = done && phase == cfg_pkg::POLL &&
                      step == 5'(cfg_pkg::STATUS_LEN - 1);

    always_ff @(posedge clk)
    begin
        if (byte_over && phase == cfg_pkg::POLL)
            cur.bytes[step[1:0]] <= data_out;
    end

    // A lock is only reported on the transition from idle to found.
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            prev       <= '0;
            lock_event <= 1'b0;
        end
        else
        begin
            lock_event <= word_end &&
                          prev.fields.lock == cfg_pkg::LOCK_IDLE &&
                          cur.fields.lock == cfg_pkg::LOCK_FOUND;
            if (word_end)
                prev <= cur;
        end
    end

endmodule

`default_nettype wire

// File: rtl/step_counter.sv
`default_nettype none

module step_counter (
    input  wire              clk,
    input  wire              rstn,
    input  cfg_pkg::phase_t  phase,
    input  wire              done,
    output logic [4:0]       step,
    output logic             last
);

    cfg_pkg::phase_t phase_q;
    logic [4:0]      len_m1;

    always_comb
    begin
        case (phase)
            cfg_pkg::CONNECT:  len_m1 = 5'(cfg_pkg::CONNECT_LEN - 1);
            cfg_pkg::INIT:     len_m1 = 5'(cfg_pkg::INIT_LEN - 1);
            cfg_pkg::POLL:     len_m1 = 5'(cfg_pkg::STATUS_LEN - 1);
            cfg_pkg::SETTINGS: len_m1 = 5'(cfg_pkg::SETTINGS_LEN - 1);
            default:           len_m1 = 5'd0;
        endcase
    end

    assign last = (step == len_m1);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            step    <= 5'd0;
            phase_q <= cfg_pkg::IDLE;
        end
        else
        begin
            phase_q <= phase;
            if (phase != phase_q)
                step <= 5'd0;
            else if (done)
                step <= last ? 5'd0 : step + 5'd1;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_top -f project.f -o sim_tb \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

// File: testbench/cfg_chk.sv
`default_nettype none

module cfg_chk (
    input  wire         clk,
    input  wire         rstn,
    input  wire         iic_trig,
    input  wire         busy,
    input  wire [15:0]  addr,
    input  wire         init_over
);

    a_trig_pulse: assert property (@(posedge clk) disable iff (!rstn)
        iic_trig |=> !iic_trig)
        else $error("iic_trig stayed high for more than one cycle");

    a_trig_idle: assert property (@(posedge clk) disable iff (!rstn)
        busy |-> !iic_trig)
        else $error("iic_trig pulsed while busy was high");

    a_addr_hold: assert property (@(posedge clk) disable iff (!rstn)
        busy |-> $stable(addr))
        else $error("addr changed while busy was high");

    // Once configured, the receiver stays configured.
    a_init_sticky: assert property (@(posedge clk) disable iff (!rstn)
        init_over |=> init_over)
        else $error("init_over fell after it was set");

endmodule

bind ms7200_cfg_top cfg_chk i_chk (
    .clk       (clk),
    .rstn      (rstn),
    .iic_trig  (iic_trig),
    .busy      (busy),
    .addr      (addr),
    .init_over (init_over)
);

`default_nettype wire

// File: testbench/cfg_trace.txt
# kind addr value (hex). W: expected data_in of a write. R: byte returned for a read.
# L: expected init_over level from the next transaction on (addr unused).
L 0000 0
W 0003 5A
R 0003 A5
W 0003 5A
R 0003 5A
W 0204 02
W 0205 40
W 0004 01
W 0009 26
W 102E 01
W 1025 B0
W 102D 83
W 1000 20
W 100F 04
W 0003 C3
W 103B 02
W 00E1 00
W 00A8 08
W 000A 00
W 0016 02
W 00E2 01
R 209C 3C
R 209D 00
R 209E 04
R 209F 00
R 209C 3C
R 209D 00
R 209E 06
R 209F 00
W 1010 01
W 1024 00
W 0200 00
W 1024 70
W 0200 07
W 0215 01
W 0215 00
L 0000 1
R 209C 3C
R 209D 00
R 209E 02
R 209F 00
R 209C 3C

// File: testbench/tb_top.sv
`default_nettype none

module tb_top;

    localparam int TRIG_TIMEOUT = 200;

    logic        clk = 1'b0;
    logic        rstn;
    logic        busy;
    logic [7:0]  data_out;
    logic        byte_over;
    wire         init_over;
    wire         iic_trig;
    wire         w_r;
    wire [15:0]  addr;
    wire [7:0]   data_in;

    integer seed = 71;
    int     checks = 0;
    int     errors = 0;
    int     failures = 0;
    logic   exp_init_over = 1'b0;

    ms7200_cfg_top i_dut (
        .clk       (clk),
        .rstn      (rstn),
        .init_over (init_over),
        .iic_trig  (iic_trig),
        .w_r       (w_r),
        .addr      (addr),
        .data_in   (data_in),
        .busy      (busy),
        .data_out  (data_out),
        .byte_over (byte_over)
    );

    always #5 clk = ~clk;

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("** Error at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they settle.
    task automatic wait_trig(output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < TRIG_TIMEOUT)
        begin
            @(negedge clk);
            seen = iic_trig;
            cycles++;
        end
    endtask

    // Model of the I2C master and slave for one transaction. A read returns
    // its byte with byte_over in the last cycle that busy is high.
    task automatic serve_master(input bit is_read, input logic [7:0] rdata);
        int delay;
        int len;
        delay = 1 + ($unsigned($random(seed)) % 4);
        len = 3 + ($unsigned($random(seed)) % 8);
        repeat (delay) @(posedge clk);
        #1 busy = 1'b1;
        repeat (len - 1) @(posedge clk);
        #1;
        if (is_read)
        begin
            byte_over = 1'b1;
            data_out = rdata;
        end
        @(posedge clk);
        #1;
        busy = 1'b0;
        byte_over = 1'b0;
    endtask

    initial
    begin
        int          fd;
        int          n;
        int          txns;
        string       line;
        logic [7:0]  kind;
        logic [15:0] t_addr;
        logic [7:0]  t_val;
        bit          seen;
        bit          stop;

        txns = 0;
        stop = 1'b0;
        rstn = 1'b0;
        busy = 1'b0;
        data_out = 8'h00;
        byte_over = 1'b0;
        repeat (15) @(posedge clk);
        @(negedge clk);
        compare("iic_trig", 32'd0, 32'(iic_trig));
        compare("init_over", 32'd0, 32'(init_over));
        compare("w_r", 32'd1, 32'(w_r));
        compare("addr", 32'd0, 32'(addr));
        compare("data_in", 32'd0, 32'(data_in));
        @(posedge clk);
        #1 rstn = 1'b1;

        fd = $fopen("testbench/cfg_trace.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the trace file testbench/cfg_trace.txt.");
            failures++;
            stop = 1'b1;
        end
        while (!stop && !$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line[0] == "#")
                continue;
            if ($sscanf(line, "%c %h %h", kind, t_addr, t_val) != 3)
                continue;
            if (kind == "L")
            begin
                exp_init_over = t_val[0];
                continue;
            end
            wait_trig(seen);
            if (!seen)
            begin
                $display("Timed out at %0t waiting for the transaction to register 0x%04h.",
                         $time, t_addr);
                failures++;
                stop = 1'b1;
            end
            else
            begin
                txns++;
                compare("w_r", 32'(kind == "W"), 32'(w_r));
                compare("addr", 32'(t_addr), 32'(addr));
                if (kind == "W")
                    compare("data_in", 32'(t_val), 32'(data_in));
                compare("init_over", 32'(exp_init_over), 32'(init_over));
                serve_master(kind == "R", t_val);
            end
        end
        if (fd != 0)
            $fclose(fd);
        if (fd != 0 && txns == 0)
        begin
            $display("The trace file held no transactions.");
            failures++;
        end

        $display("Checks %0d, value errors %0d, other failures %0d, transactions %0d",
                 checks, errors, failures, txns);
        if (errors == 0 && failures == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
